//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_raytracer
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
rt_pkg.sv
rt_hit_if.sv
rt_ray_gen.sv
rt_sphere_search.sv
rt_shader.sv
raytracer_top.sv
tb_raytracer_assert.sv
tb_raytracer.sv

//--- raytracer_top.sv
// Raytracer top level: one pixel in, one shaded color out NUM_SPHERES + 3 cycles later
module raytracer_top #(
    parameter int NUM_SPHERES = rt_pkg::SCENE_SIZE
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [rt_pkg::PIX_X_W-1:0] pixel_x_i,
    input  logic [rt_pkg::PIX_Y_W-1:0] pixel_y_i,
    input  logic                       pixel_valid_i,
    output logic [7:0]                 rgb_r_o,
    output logic [7:0]                 rgb_g_o,
    output logic [7:0]                 rgb_b_o,
    output logic                       output_valid_o,
    output logic                       busy_o
);
    import rt_pkg::*;

    logic  ray_valid;
    vec3_t ray_dir;
    rgb_t  color;

    rt_hit_if #(.NUM_SPHERES(NUM_SPHERES)) hit_bus ();

    rt_ray_gen u_ray_gen (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pixel_valid_i (pixel_valid_i),
        .pixel_x_i     (pixel_x_i),
        .pixel_y_i     (pixel_y_i),
        .busy_i        (busy_o),
        .ray_valid_o   (ray_valid),
        .ray_dir_o     (ray_dir)
    );

    rt_sphere_search #(
        .NUM_SPHERES (NUM_SPHERES)
    ) u_search (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ray_valid_i (ray_valid),
        .ray_dir_i   (ray_dir),
        .busy_o      (busy_o),
        .hit_if      (hit_bus)
    );

    rt_shader u_shader (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .hit_if        (hit_bus),
        .color_o       (color),
        .color_valid_o (output_valid_o)
    );

    assign rgb_r_o = color.r;
    assign rgb_g_o = color.g;
    assign rgb_b_o = color.b;

endmodule

//--- rt_hit_if.sv
// Nearest-hit result bus from the sphere search to the shader, read while done is high
interface rt_hit_if #(
    parameter int NUM_SPHERES = rt_pkg::SCENE_SIZE
);
    import rt_pkg::*;

    localparam int IDX_W = idx_width(NUM_SPHERES);

    // One-cycle strobe, fields hold until the next one
    logic             done;
    logic             hit;
    q16_t             t;
    logic [IDX_W-1:0] sphere_idx;
    vec3_t            dir;

    modport source (
        output done,
        output hit,
        output t,
        output sphere_idx,
        output dir
    );

    modport sink (
        input done,
        input hit,
        input t,
        input sphere_idx,
        input dir
    );

endinterface

//--- rt_pkg.sv
// Q16.16 types, fixed-point math, scene table and constants shared by the raytracer and its testbench
package rt_pkg;

    typedef logic signed [31:0] q16_t;

    typedef struct packed {
        q16_t x;
        q16_t y;
        q16_t z;
    } vec3_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        vec3_t center;
        q16_t  radius;
        rgb_t  color;
    } sphere_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DONE
    } search_state_t;

    localparam q16_t Q16_ONE = 32'sh0001_0000;
    localparam q16_t Q16_MAX = 32'sh7fff_ffff;

    localparam int SCREEN_CX  = 320;
    localparam int SCREEN_CY  = 240;
    localparam int PIX_X_W    = 10;
    localparam int PIX_Y_W    = 9;
    localparam int SCENE_SIZE = 4;

    function automatic q16_t q16_int(input int v);
        return q16_t'(v) <<< 16;
    endfunction

    // Index width for a sphere count, never below one bit
    function automatic int idx_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    function automatic q16_t q16_mul(input q16_t a, input q16_t b);
        logic signed [63:0] prod;
        prod = a * b;
        prod = prod + 64'sd32768;
        return prod[47:16];
    endfunction

    function automatic q16_t q16_div(input q16_t a, input q16_t b);
        logic signed [63:0] num;
        logic signed [63:0] den;
        logic signed [63:0] quo;
        if (b == 0) begin
            return (a >= 0) ? Q16_MAX : -Q16_MAX;
        end
        num = a;
        den = b;
        quo = (num <<< 16) / den;
        return quo[31:0];
    endfunction

    // Each product is truncated to Q16 before the sum
    function automatic q16_t q16_dot3(input vec3_t a, input vec3_t b);
        logic signed [63:0] px;
        logic signed [63:0] py;
        logic signed [63:0] pz;
        px = (a.x * b.x) >>> 16;
        py = (a.y * b.y) >>> 16;
        pz = (a.z * b.z) >>> 16;
        return px[31:0] + py[31:0] + pz[31:0];
    endfunction

    // Digit-by-digit integer root of a << 16
    function automatic q16_t q16_sqrt(input q16_t a);
        logic [63:0] v;
        logic [63:0] rem;
        logic [63:0] root;
        if (a <= 0) begin
            return '0;
        end
        v = {32'h0, a} << 16;
        rem = '0;
        root = '0;
        for (int i = 23; i >= 0; i--) begin
            rem = (rem << 2) | ((v >> (2 * i)) & 64'd3);
            if (rem >= ((root << 2) | 64'd1)) begin
                rem = rem - ((root << 2) | 64'd1);
                root = (root << 1) | 64'd1;
            end else begin
                root = root << 1;
            end
        end
        return q16_t'(root[31:0]);
    endfunction

    function automatic vec3_t vec_normalize(input vec3_t v);
        q16_t  mag;
        vec3_t n;
        mag = q16_sqrt(q16_dot3(v, v));
        n = '0;
        if (mag > 0) begin
            n.x = q16_div(v.x, mag);
            n.y = q16_div(v.y, mag);
            n.z = q16_div(v.z, mag);
        end
        return n;
    endfunction

    // Ray from the camera origin, nearest positive root in t
    function automatic logic ray_sphere(input vec3_t dir, input sphere_t s, output q16_t t);
        vec3_t l;
        q16_t  a;
        q16_t  half_b;
        q16_t  c;
        q16_t  disc;
        q16_t  root;
        q16_t  t0;
        q16_t  t1;
        logic  hit;
        l.x = -s.center.x;
        l.y = -s.center.y;
        l.z = -s.center.z;
        a = q16_dot3(dir, dir);
        half_b = q16_dot3(l, dir);
        c = q16_dot3(l, l) - q16_mul(s.radius, s.radius);
        disc = q16_mul(half_b, half_b) - q16_mul(a, c);
        hit = 1'b0;
        t = '0;
        if (disc >= 0 && a != 0) begin
            root = q16_sqrt(disc);
            t0 = q16_div(-half_b - root, a);
            t1 = q16_div(-half_b + root, a);
            if (t0 > 0 && (t1 <= 0 || t0 < t1)) begin
                hit = 1'b1;
                t = t0;
            end else if (t1 > 0) begin
                hit = 1'b1;
                t = t1;
            end
        end
        return hit;
    endfunction

    function automatic logic [7:0] clamp_u8(input int v);
        if (v < 0) begin
            return 8'd0;
        end
        if (v > 255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

    localparam q16_t  RAY_Z           = q16_int(100);
    localparam rgb_t  BG_COLOR        = '{r: 8'd0, g: 8'd0, b: 8'd32};
    localparam vec3_t LIGHT_POS       = '{x: q16_int(-5), y: q16_int(6), z: q16_int(-2)};
    localparam rgb_t  LIGHT_COLOR     = '{r: 8'd255, g: 8'd240, b: 8'd220};
    localparam q16_t  LIGHT_INTENSITY = Q16_ONE;

    function automatic sphere_t make_sphere(input int cx, input int cy, input int cz,
                                            input q16_t radius,
                                            input logic [7:0] cr, input logic [7:0] cg,
                                            input logic [7:0] cb);
        sphere_t s;
        s.center.x = q16_int(cx);
        s.center.y = q16_int(cy);
        s.center.z = q16_int(cz);
        s.radius = radius;
        s.color = '{r: cr, g: cg, b: cb};
        return s;
    endfunction

    // Slots past the table are radius zero at the origin and never hit
    function automatic sphere_t scene_sphere(input int idx);
        case (idx)
            0:       return make_sphere(0, 0, 6, 32'sh0001_8000, 8'd200, 8'd60, 8'd60);
            1:       return make_sphere(-3, -1, 10, q16_int(2), 8'd60, 8'd200, 8'd80);
            2:       return make_sphere(3, 1, 12, 32'sh0002_8000, 8'd70, 8'd90, 8'd220);
            3:       return make_sphere(2, 3, 15, Q16_ONE, 8'd230, 8'd210, 8'd60);
            default: return '0;
        endcase
    endfunction

endpackage

//--- rt_ray_gen.sv
// Primary ray generator: takes an accepted pixel and registers its unit ray direction
module rt_ray_gen (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       pixel_valid_i,
    input  logic [rt_pkg::PIX_X_W-1:0] pixel_x_i,
    input  logic [rt_pkg::PIX_Y_W-1:0] pixel_y_i,
    input  logic                       busy_i,
    output logic                       ray_valid_o,
    output rt_pkg::vec3_t              ray_dir_o
);
    import rt_pkg::*;

    logic  accept;
    q16_t  off_x;
    q16_t  off_y;
    vec3_t raw_dir;
    vec3_t unit_dir;

    assign accept = pixel_valid_i && !busy_i;

    // Offsets from the screen center, y grows upward
    assign off_x = q16_t'(int'(pixel_x_i) - SCREEN_CX);
    assign off_y = q16_t'(SCREEN_CY - int'(pixel_y_i));

    // One pixel step is 1/4 in Q16
    assign raw_dir = '{x: off_x <<< 14, y: off_y <<< 14, z: RAY_Z};
    assign unit_dir = vec_normalize(raw_dir);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ray_valid_o <= 1'b0;
        end else begin
            ray_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ray_dir_o <= unit_dir;
        end
    end

endmodule

//--- rt_shader.sv
// Lambert shader for one point light, registers the final color on the search done strobe
module rt_shader (
    input  logic         clk,
    input  logic         rst_n_i,
    rt_hit_if.sink       hit_if,
    output rt_pkg::rgb_t color_o,
    output logic         color_valid_o
);
    import rt_pkg::*;

    sphere_t sph;
    vec3_t   point;
    vec3_t   rel;
    vec3_t   normal;
    vec3_t   to_light;
    vec3_t   light_dir;
    q16_t    ndotl;
    int      diffuse;
    rgb_t    lit;
    rgb_t    next_color;

    // Ambient of base/8 plus tinted diffuse scaled by factor/16
    function automatic logic [7:0] shade_channel(input logic [7:0] base,
                                                 input logic [7:0] light,
                                                 input int factor);
        int tinted;
        tinted = (int'(base) * int'(light)) >>> 8;
        return clamp_u8((int'(base) >>> 3) + ((tinted * factor) >>> 4));
    endfunction

    assign sph = scene_sphere(int'(hit_if.sphere_idx));

    always_comb begin
        point.x = q16_mul(hit_if.t, hit_if.dir.x);
        point.y = q16_mul(hit_if.t, hit_if.dir.y);
        point.z = q16_mul(hit_if.t, hit_if.dir.z);

        rel.x = point.x - sph.center.x;
        rel.y = point.y - sph.center.y;
        rel.z = point.z - sph.center.z;
        normal = vec_normalize(rel);

        to_light.x = LIGHT_POS.x - point.x;
        to_light.y = LIGHT_POS.y - point.y;
        to_light.z = LIGHT_POS.z - point.z;
        light_dir = vec_normalize(to_light);

        ndotl = q16_dot3(normal, light_dir);
        diffuse = q16_mul(ndotl, LIGHT_INTENSITY) >>> 12;
        if (diffuse > 16) begin
            diffuse = 16;
        end
        if (diffuse < 0) begin
            diffuse = 0;
        end

        lit.r = shade_channel(sph.color.r, LIGHT_COLOR.r, diffuse);
        lit.g = shade_channel(sph.color.g, LIGHT_COLOR.g, diffuse);
        lit.b = shade_channel(sph.color.b, LIGHT_COLOR.b, diffuse);

        next_color = hit_if.hit ? lit : BG_COLOR;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            color_o <= '0;
            color_valid_o <= 1'b0;
        end else begin
            color_valid_o <= hit_if.done;
            if (hit_if.done) begin
                color_o <= next_color;
            end
        end
    end

endmodule

//--- rt_sphere_search.sv
// Sequential nearest-hit search, one scene sphere per clock, result handed out on rt_hit_if
module rt_sphere_search #(
    parameter int NUM_SPHERES = rt_pkg::SCENE_SIZE
) (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          ray_valid_i,
    input  rt_pkg::vec3_t ray_dir_i,
    output logic          busy_o,
    rt_hit_if.source      hit_if
);
    import rt_pkg::*;

    localparam int               IDX_W    = idx_width(NUM_SPHERES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_SPHERES - 1);

    search_state_t    state_q;
    logic [IDX_W-1:0] idx_q;
    logic             done_q;
    logic             finish_q;

    vec3_t            dir_q;
    q16_t             best_t_q;
    logic [IDX_W-1:0] best_idx_q;

    logic             res_hit_q;
    q16_t             res_t_q;
    logic [IDX_W-1:0] res_idx_q;
    vec3_t            res_dir_q;

    logic             cur_hit;
    q16_t             cur_t;
    logic             closer;

    always_comb begin
        cur_hit = ray_sphere(dir_q, scene_sphere(int'(idx_q)), cur_t);
    end

    // Strict compare keeps the lower index on a tie
    assign closer = cur_hit && (cur_t < best_t_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            idx_q <= '0;
            done_q <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            finish_q <= done_q;
            case (state_q)
                IDLE: begin
                    if (ray_valid_i) begin
                        state_q <= SCAN;
                        idx_q <= '0;
                    end
                end
                SCAN: begin
                    if (idx_q == LAST_IDX) begin
                        state_q <= DONE;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                    done_q <= 1'b1;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && ray_valid_i) begin
            dir_q <= ray_dir_i;
            best_t_q <= Q16_MAX;
        end
        if (state_q == SCAN && closer) begin
            best_t_q <= cur_t;
            best_idx_q <= idx_q;
        end
        // Result is frozen here so the next ray cannot disturb it
        if (state_q == DONE) begin
            res_hit_q <= (best_t_q != Q16_MAX);
            res_t_q <= best_t_q;
            res_idx_q <= best_idx_q;
            res_dir_q <= dir_q;
        end
    end

    assign hit_if.done = done_q;
    assign hit_if.hit = res_hit_q;
    assign hit_if.t = res_t_q;
    assign hit_if.sphere_idx = res_idx_q;
    assign hit_if.dir = res_dir_q;

    // Covers the ray cycle before SCAN and the shader cycle after done
    assign busy_o = ray_valid_i || (state_q != IDLE) || done_q || finish_q;

endmodule

//--- tb_raytracer.sv
// Testbench for raytracer_top: sends pixels, predicts colors from the fixed-point rules, checks timing
module tb_raytracer;
    import rt_pkg::*;

    localparam int NUM_SPHERES = SCENE_SIZE;
    localparam int LATENCY     = NUM_SPHERES + 3;
    localparam int WAIT_LIMIT  = 200;

    logic clk;
    logic rst_n_i;
    logic [PIX_X_W-1:0] pixel_x_i;
    logic [PIX_Y_W-1:0] pixel_y_i;
    logic pixel_valid_i;
    logic [7:0] rgb_r_o;
    logic [7:0] rgb_g_o;
    logic [7:0] rgb_b_o;
    logic output_valid_o;
    logic busy_o;

    int   seed;
    int   cyc;
    int   checks;
    int   value_errors;
    int   other_errors;
    int   accepted;
    int   results;
    bit   run_over;
    rgb_t last_color;
    rgb_t exp_q[$];
    int   due_q[$];

    raytracer_top dut0 (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [7:0] lambert_channel(input int base, input int tint, input int factor);
        return clamp_u8(base / 8 + ((base * tint) / 256) * factor / 16);
    endfunction

    // Expected color of one pixel, hit_idx is -1 on a miss
    function automatic rgb_t ref_pixel(input int px, input int py, output int hit_idx);
        vec3_t   dir;
        vec3_t   p;
        vec3_t   n;
        vec3_t   l;
        sphere_t s;
        q16_t    t;
        q16_t    best_t;
        logic    hit;
        int      factor;
        dir.x = q16_t'(px - SCREEN_CX) <<< 14;
        dir.y = q16_t'(SCREEN_CY - py) <<< 14;
        dir.z = RAY_Z;
        dir = vec_normalize(dir);
        hit_idx = -1;
        best_t = Q16_MAX;
        for (int i = 0; i < NUM_SPHERES; i++) begin
            hit = ray_sphere(dir, scene_sphere(i), t);
            if (hit && t < best_t) begin
                best_t = t;
                hit_idx = i;
            end
        end
        if (hit_idx < 0) begin
            return BG_COLOR;
        end
        s = scene_sphere(hit_idx);
        p.x = q16_mul(best_t, dir.x);
        p.y = q16_mul(best_t, dir.y);
        p.z = q16_mul(best_t, dir.z);
        n.x = p.x - s.center.x;
        n.y = p.y - s.center.y;
        n.z = p.z - s.center.z;
        l.x = LIGHT_POS.x - p.x;
        l.y = LIGHT_POS.y - p.y;
        l.z = LIGHT_POS.z - p.z;
        factor = q16_mul(q16_dot3(vec_normalize(n), vec_normalize(l)), LIGHT_INTENSITY) >>> 12;
        factor = (factor > 16) ? 16 : ((factor < 0) ? 0 : factor);
        return '{r: lambert_channel(s.color.r, LIGHT_COLOR.r, factor),
                 g: lambert_channel(s.color.g, LIGHT_COLOR.g, factor),
                 b: lambert_channel(s.color.b, LIGHT_COLOR.b, factor)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
        checks++;
        assert (got === want) else begin
            value_errors++;
            $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, want, got);
        end
    endtask

    task automatic finish_run();
        if (!run_over) begin
            run_over = 1'b1;
            other_errors += dut0.u_assert.assert_failures;
            $display("Checks %0d, value errors %0d, other errors %0d, pixels %0d, results %0d",
                     checks, value_errors, other_errors, accepted, results);
            if (value_errors == 0 && other_errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    endtask

    task automatic fail_now(input string msg);
        other_errors++;
        $display("%s", msg);
        finish_run();
    endtask

    // Called just after a rising edge, returns just after the accepting edge
    task automatic send_pixel(input int x, input int y);
        int   n;
        int   idx;
        n = 0;
        while (busy_o !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy_o !== 1'b0) begin
            fail_now("Timed out waiting for busy_o to drop before sending a pixel");
        end else begin
            pixel_x_i = x[PIX_X_W-1:0];
            pixel_y_i = y[PIX_Y_W-1:0];
            pixel_valid_i = 1'b1;
            exp_q.push_back(ref_pixel(x, y, idx));
            due_q.push_back(cyc + 1 + LATENCY);
            accepted++;
            @(posedge clk);
            #1;
            pixel_valid_i = 1'b0;
        end
    endtask

    // Strobe stays high over the whole busy window of the pixel in flight
    task automatic offer_while_busy(input int x, input int y);
        int n;
        n = 0;
        assert (busy_o === 1'b1) else begin
            other_errors++;
            $display("busy_o was low right after a pixel was accepted");
        end
        pixel_x_i = x[PIX_X_W-1:0];
        pixel_y_i = y[PIX_Y_W-1:0];
        while (busy_o === 1'b1 && n < WAIT_LIMIT) begin
            pixel_valid_i = 1'b1;
            @(posedge clk);
            #1;
            n++;
        end
        pixel_valid_i = 1'b0;
        if (busy_o !== 1'b0) begin
            fail_now("Timed out offering pixels while busy_o stayed high");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() > 0 || busy_o !== 1'b0) && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() > 0) begin
            fail_now("Timed out waiting for output_valid_o of a sent pixel");
        end else if (busy_o !== 1'b0) begin
            fail_now("Timed out waiting for busy_o to drop after the last result");
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        rgb_t want;
        int   due;
        if (rst_n_i && output_valid_o === 1'b1) begin
            results++;
            last_color = '{r: rgb_r_o, g: rgb_g_o, b: rgb_b_o};
            assert (exp_q.size() > 0) else begin
                other_errors++;
                $display("output_valid_o pulsed at cycle %0d with no pixel pending", cyc);
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                due = due_q.pop_front();
                check_value("rgb_r_o", want.r, rgb_r_o);
                check_value("rgb_g_o", want.g, rgb_g_o);
                check_value("rgb_b_o", want.b, rgb_b_o);
                assert (cyc == due) else begin
                    other_errors++;
                    $display("output_valid_o came at cycle %0d instead of cycle %0d", cyc, due);
                end
            end
        end
    end

    initial begin : stimulus
        int      idx;
        int      x;
        int      y;
        rgb_t    amb;
        sphere_t front;
        rst_n_i = 1'b0;
        pixel_valid_i = 1'b0;
        pixel_x_i = '0;
        pixel_y_i = '0;
        seed = 32'hde1f_4ff7;
        cyc = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_value("output_valid_o", 0, output_valid_o);
        check_value("busy_o", 0, busy_o);
        check_value("rgb", 0, {rgb_r_o, rgb_g_o, rgb_b_o});

        // Screen corners see only background
        send_pixel(0, 0);
        wait_drain();
        check_value("rgb", BG_COLOR, last_color);
        send_pixel(639, 479);
        wait_drain();
        check_value("rgb", BG_COLOR, last_color);

        send_pixel(SCREEN_CX, SCREEN_CY);
        wait_drain();
        void'(ref_pixel(SCREEN_CX, SCREEN_CY, idx));
        check_value("center sphere index", 0, idx);
        front = scene_sphere(0);
        amb = '{r: front.color.r >> 3, g: front.color.g >> 3, b: front.color.b >> 3};
        assert (last_color.r > amb.r || last_color.g > amb.g || last_color.b > amb.b) else begin
            other_errors++;
            $display("Center pixel is no brighter than the ambient-only color of the front sphere");
        end

        for (int i = 0; i < 40; i++) begin
            x = $unsigned($random(seed)) % 640;
            y = $unsigned($random(seed)) % 480;
            send_pixel(x, y);
        end
        wait_drain();

        // Pixels offered during a search are dropped
        send_pixel(100, 200);
        offer_while_busy(SCREEN_CX, SCREEN_CY);
        wait_drain();
        assert (results == accepted) else begin
            other_errors++;
            $display("Got %0d results for %0d accepted pixels", results, accepted);
        end
        finish_run();
    end

endmodule

//--- tb_raytracer_assert.sv
// Concurrent output handshake checks, bound into raytracer_top by the bind at the end of this file
module tb_raytracer_assert (
    input logic       clk,
    input logic       rst_n_i,
    input logic       output_valid_i,
    input logic       busy_i,
    input logic [7:0] rgb_r_i,
    input logic [7:0] rgb_g_i,
    input logic [7:0] rgb_b_i
);
    int assert_failures;

    initial assert_failures = 0;

    // A result is a one-cycle pulse
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        output_valid_i |=> !output_valid_i)
        else begin
            assert_failures++;
            $error("output_valid_o was high for two cycles in a row");
        end

    // The shader cycle is the last busy one
    busy_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        output_valid_i |=> !busy_i)
        else begin
            assert_failures++;
            $error("busy_o still high in the cycle after output_valid_o");
        end

    color_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        !output_valid_i |-> $stable({rgb_r_i, rgb_g_i, rgb_b_i}))
        else begin
            assert_failures++;
            $error("rgb outputs changed while output_valid_o was low");
        end

endmodule

bind raytracer_top tb_raytracer_assert u_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .output_valid_i (output_valid_o),
    .busy_i         (busy_o),
    .rgb_r_i        (rgb_r_o),
    .rgb_g_i        (rgb_g_o),
    .rgb_b_i        (rgb_b_o)
);
